// ==== design/arm_pkg.sv ====
package arm_pkg;

    typedef logic [31:0] word_t;     // Data, instruction or byte address
    typedef logic [3:0]  reg_idx_t;
    typedef logic [3:0]  flags_t;    // N Z C V
    typedef logic [3:0]  cond_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,     // A - B
        ALU_RSB,     // B - A
        ALU_AND,
        ALU_EOR,
        ALU_ORR,
        ALU_MOVB,    // Pass B
        ALU_MVN,
        ALU_BIC
    } alu_op_t;

    typedef enum logic [1:0] {
        FWD_RF,
        FWD_EX,
        FWD_WB
    } fwd_sel_t;

    typedef enum logic [1:0] {
        SH_LSL,
        SH_LSR,
        SH_ASR,
        SH_ROR
    } shift_t;

    localparam word_t NOP_WORD = '0;
    localparam int    NUM_REGS = 16;

    // Instruction fields
    localparam int COND_HI  = 31;
    localparam int COND_LO  = 28;
    localparam int CLASS_HI = 27;
    localparam int CLASS_LO = 25;
    localparam int L_BIT    = 24;   // B vs BL
    localparam int OPC_HI   = 24;
    localparam int OPC_LO   = 21;
    localparam int S_BIT    = 20;
    localparam int RN_HI    = 19;
    localparam int RN_LO    = 16;
    localparam int RD_HI    = 15;
    localparam int RD_LO    = 12;
    localparam int RSH_BIT  = 4;    // Register-specified shift
    localparam int RM_HI    = 3;
    localparam int RM_LO    = 0;

    localparam logic [2:0] CLASS_DP_REG = 3'b000;
    localparam logic [2:0] CLASS_DP_IMM = 3'b001;
    localparam logic [2:0] CLASS_BRANCH = 3'b101;

    // Data-processing opcodes
    localparam logic [3:0] OPC_AND = 4'b0000;
    localparam logic [3:0] OPC_EOR = 4'b0001;
    localparam logic [3:0] OPC_SUB = 4'b0010;
    localparam logic [3:0] OPC_RSB = 4'b0011;
    localparam logic [3:0] OPC_ADD = 4'b0100;
    localparam logic [3:0] OPC_CMP = 4'b1010;
    localparam logic [3:0] OPC_CMN = 4'b1011;
    localparam logic [3:0] OPC_ORR = 4'b1100;
    localparam logic [3:0] OPC_MOV = 4'b1101;
    localparam logic [3:0] OPC_BIC = 4'b1110;
    localparam logic [3:0] OPC_MVN = 4'b1111;

    localparam int FLAG_N = 3;
    localparam int FLAG_Z = 2;
    localparam int FLAG_C = 1;
    localparam int FLAG_V = 0;

endpackage

// ==== design/fetch_stage.sv ====
`timescale 1ns/10ps

module fetch_stage #(
    parameter int IMEM_WORDS = 64
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           run,
    input  logic           psel,
    input  logic           penable,
    input  logic           pwrite,
    input  arm_pkg::word_t paddr,
    input  arm_pkg::word_t pwdata,
    input  logic           branch_taken,
    input  arm_pkg::word_t branch_target,
    output arm_pkg::word_t prdata,
    output logic           pready,
    output arm_pkg::word_t if_instr,
    output arm_pkg::word_t if_pc
);

    localparam int AW = $clog2(IMEM_WORDS);

    arm_pkg::word_t imem [IMEM_WORDS];
    arm_pkg::word_t pc;
    logic [AW-1:0]  apb_idx;
    logic [AW-1:0]  pc_idx;
    logic           pc_in_range;

    assign apb_idx     = paddr[AW+1:2];
    assign pc_idx      = pc[AW+1:2];
    assign pc_in_range = (pc >> 2) < arm_pkg::word_t'(IMEM_WORDS);

    // Zero-wait APB slave, write lands in the access phase
    always_ff @(posedge clk) begin
        if (psel && penable && pwrite) begin
            imem[apb_idx] <= pwdata;
        end
    end

    assign prdata = imem[apb_idx];
    assign pready = 1'b1;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (run) begin
            if (branch_taken) begin
                pc <= branch_target;
            end else begin
                pc <= pc + 32'd4;
            end
        end
    end

    // Fetch/decode register
    always_ff @(posedge clk) begin
        if (rst) begin
            if_instr <= arm_pkg::NOP_WORD;
        end else if (!run || branch_taken || !pc_in_range) begin
            if_instr <= arm_pkg::NOP_WORD;  // Flush or idle
        end else begin
            if_instr <= imem[pc_idx];
        end
    end

    always_ff @(posedge clk) begin
        if_pc <= pc;
    end

endmodule

// ==== design/decode_stage.sv ====
`timescale 1ns/10ps

module decode_stage (
    input  logic               clk,
    input  logic               rst,
    input  logic               branch_taken,
    input  arm_pkg::word_t     if_instr,
    input  arm_pkg::word_t     if_pc,
    input  logic               wb_valid,
    input  arm_pkg::reg_idx_t  wb_reg,
    input  arm_pkg::word_t     wb_data,
    input  logic               ex_fwd_valid,
    input  arm_pkg::reg_idx_t  ex_fwd_reg,
    input  arm_pkg::word_t     ex_fwd_data,
    output arm_pkg::alu_op_t   ex_op,
    output logic               ex_set_flags,
    output logic               ex_write,
    output logic               ex_is_branch,
    output arm_pkg::cond_t     ex_cond,
    output arm_pkg::word_t     ex_a,
    output arm_pkg::word_t     ex_b_raw,
    output logic [11:0]        ex_imm12,
    output logic               ex_use_imm,
    output arm_pkg::reg_idx_t  ex_rd,
    output arm_pkg::word_t     ex_pc
);

    arm_pkg::word_t    rf [arm_pkg::NUM_REGS];
    logic [2:0]        cls;
    logic [3:0]        opc;
    arm_pkg::reg_idx_t rn;
    arm_pkg::reg_idx_t rm;
    logic              is_dp;
    logic              is_br;
    arm_pkg::alu_op_t  dec_op;
    logic              dec_write;
    logic              dec_set_flags;
    arm_pkg::fwd_sel_t sel_a;
    arm_pkg::fwd_sel_t sel_b;
    arm_pkg::word_t    op_a;
    arm_pkg::word_t    op_b;

    assign cls = if_instr[arm_pkg::CLASS_HI:arm_pkg::CLASS_LO];
    assign opc = if_instr[arm_pkg::OPC_HI:arm_pkg::OPC_LO];
    assign rn  = if_instr[arm_pkg::RN_HI:arm_pkg::RN_LO];
    assign rm  = if_instr[arm_pkg::RM_HI:arm_pkg::RM_LO];

    // Register-specified shifts fall through as NOP
    assign is_dp = (if_instr != arm_pkg::NOP_WORD) &&
                   ((cls == arm_pkg::CLASS_DP_REG && !if_instr[arm_pkg::RSH_BIT]) ||
                    cls == arm_pkg::CLASS_DP_IMM);
    assign is_br = (cls == arm_pkg::CLASS_BRANCH) && !if_instr[arm_pkg::L_BIT];

    always_comb begin
        dec_op        = arm_pkg::ALU_AND;
        dec_write     = 1'b0;
        dec_set_flags = 1'b0;
        if (is_dp) begin
            dec_write     = 1'b1;
            dec_set_flags = if_instr[arm_pkg::S_BIT];
            case (opc)
                arm_pkg::OPC_AND: dec_op = arm_pkg::ALU_AND;
                arm_pkg::OPC_EOR: dec_op = arm_pkg::ALU_EOR;
                arm_pkg::OPC_SUB: dec_op = arm_pkg::ALU_SUB;
                arm_pkg::OPC_RSB: dec_op = arm_pkg::ALU_RSB;
                arm_pkg::OPC_ADD: dec_op = arm_pkg::ALU_ADD;
                arm_pkg::OPC_ORR: dec_op = arm_pkg::ALU_ORR;
                arm_pkg::OPC_MOV: dec_op = arm_pkg::ALU_MOVB;
                arm_pkg::OPC_BIC: dec_op = arm_pkg::ALU_BIC;
                arm_pkg::OPC_MVN: dec_op = arm_pkg::ALU_MVN;
                arm_pkg::OPC_CMP: begin
                    dec_op        = arm_pkg::ALU_SUB;
                    dec_write     = 1'b0;
                    dec_set_flags = 1'b1;
                end
                arm_pkg::OPC_CMN: begin
                    dec_op        = arm_pkg::ALU_ADD;
                    dec_write     = 1'b0;
                    dec_set_flags = 1'b1;
                end
                default: begin          // Carry ops, TST, TEQ
                    dec_write     = 1'b0;
                    dec_set_flags = 1'b0;
                end
            endcase
        end
    end

    // Youngest producer wins
    function automatic arm_pkg::fwd_sel_t pick_src(
        input arm_pkg::reg_idx_t r,
        input logic              exv,
        input arm_pkg::reg_idx_t exr,
        input logic              wbv,
        input arm_pkg::reg_idx_t wbr
    );
        if (exv && exr == r) begin
            return arm_pkg::FWD_EX;
        end else if (wbv && wbr == r) begin
            return arm_pkg::FWD_WB;
        end
        return arm_pkg::FWD_RF;
    endfunction

    assign sel_a = pick_src(rn, ex_fwd_valid, ex_fwd_reg, wb_valid, wb_reg);
    assign sel_b = pick_src(rm, ex_fwd_valid, ex_fwd_reg, wb_valid, wb_reg);

    always_comb begin
        case (sel_a)
            arm_pkg::FWD_EX: op_a = ex_fwd_data;
            arm_pkg::FWD_WB: op_a = wb_data;
            default:         op_a = rf[rn];
        endcase
        case (sel_b)
            arm_pkg::FWD_EX: op_b = ex_fwd_data;
            arm_pkg::FWD_WB: op_b = wb_data;
            default:         op_b = rf[rm];
        endcase
    end

    always_ff @(posedge clk) begin
        if (wb_valid) begin
            rf[wb_reg] <= wb_data;
        end
    end

    // Decode/execute register
    always_ff @(posedge clk) begin
        if (rst || branch_taken) begin
            ex_write     <= 1'b0;
            ex_set_flags <= 1'b0;
            ex_is_branch <= 1'b0;
        end else begin
            ex_write     <= dec_write;
            ex_set_flags <= dec_set_flags;
            ex_is_branch <= is_br;
        end
    end

    always_ff @(posedge clk) begin
        ex_op      <= dec_op;
        ex_cond    <= if_instr[arm_pkg::COND_HI:arm_pkg::COND_LO];
        ex_a       <= op_a;
        ex_b_raw   <= is_br ? {8'h00, if_instr[23:0]} : op_b;  // Branch offset rides here
        ex_imm12   <= if_instr[11:0];
        ex_use_imm <= (cls == arm_pkg::CLASS_DP_IMM);
        ex_rd      <= if_instr[arm_pkg::RD_HI:arm_pkg::RD_LO];
        ex_pc      <= if_pc;
    end

endmodule

// ==== design/execute_stage.sv ====
`timescale 1ns/10ps

module execute_stage (
    input  logic               clk,
    input  logic               rst,
    input  arm_pkg::alu_op_t   ex_op,
    input  logic               ex_set_flags,
    input  logic               ex_write,
    input  logic               ex_is_branch,
    input  arm_pkg::cond_t     ex_cond,
    input  arm_pkg::word_t     ex_a,
    input  arm_pkg::word_t     ex_b_raw,
    input  logic [11:0]        ex_imm12,
    input  logic               ex_use_imm,
    input  arm_pkg::reg_idx_t  ex_rd,
    input  arm_pkg::word_t     ex_pc,
    output logic               ex_fwd_valid,
    output arm_pkg::reg_idx_t  ex_fwd_reg,
    output arm_pkg::word_t     ex_fwd_data,
    output logic               wb_valid,
    output arm_pkg::reg_idx_t  wb_reg,
    output arm_pkg::word_t     wb_data,
    output arm_pkg::flags_t    flags,
    output logic               branch_taken,
    output arm_pkg::word_t     branch_target
);

    logic [4:0]       sh_amt;
    arm_pkg::shift_t  sh_type;
    arm_pkg::word_t   op_b;
    logic [32:0]      sum;
    arm_pkg::word_t   alu_res;
    logic             alu_c;
    logic             alu_v;
    logic             n;
    logic             z;
    logic             c;
    logic             v;
    logic             cond_ok;
    arm_pkg::word_t   br_offset;

    function automatic arm_pkg::word_t ror32(input arm_pkg::word_t x, input logic [4:0] amt);
        if (amt == 5'd0) begin
            return x;
        end
        return (x >> amt) | (x << (6'd32 - {1'b0, amt}));
    endfunction

    assign sh_amt  = ex_imm12[11:7];
    assign sh_type = arm_pkg::shift_t'(ex_imm12[6:5]);

    // Second operand
    always_comb begin
        if (ex_use_imm) begin
            op_b = ror32({24'h0, ex_imm12[7:0]}, {ex_imm12[11:8], 1'b0});
        end else begin
            case (sh_type)
                arm_pkg::SH_LSL: op_b = ex_b_raw << sh_amt;
                arm_pkg::SH_LSR: op_b = ex_b_raw >> sh_amt;
                arm_pkg::SH_ASR: op_b = arm_pkg::word_t'($signed(ex_b_raw) >>> sh_amt);
                default:         op_b = ror32(ex_b_raw, sh_amt);
            endcase
        end
    end

    assign sum = {1'b0, ex_a} + {1'b0, op_b};

    always_comb begin
        alu_c = 1'b0;
        alu_v = 1'b0;
        case (ex_op)
            arm_pkg::ALU_ADD: begin
                alu_res = sum[31:0];
                alu_c   = sum[32];
                alu_v   = ~(ex_a[31] ^ op_b[31]) & (ex_a[31] ^ alu_res[31]);
            end
            arm_pkg::ALU_SUB: begin
                alu_res = ex_a - op_b;
                alu_c   = (ex_a < op_b);    // Borrow, not ARM carry
                alu_v   = (ex_a[31] ^ op_b[31]) & (ex_a[31] ^ alu_res[31]);
            end
            arm_pkg::ALU_RSB: begin
                alu_res = op_b - ex_a;
                alu_c   = (op_b < ex_a);
                alu_v   = (op_b[31] ^ ex_a[31]) & (op_b[31] ^ alu_res[31]);
            end
            arm_pkg::ALU_AND:  alu_res = ex_a & op_b;
            arm_pkg::ALU_EOR:  alu_res = ex_a ^ op_b;
            arm_pkg::ALU_ORR:  alu_res = ex_a | op_b;
            arm_pkg::ALU_MOVB: alu_res = op_b;
            arm_pkg::ALU_MVN:  alu_res = ~op_b;
            default:           alu_res = ex_a & ~op_b;  // BIC
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            flags <= '0;
        end else if (ex_set_flags) begin
            flags <= {alu_res[31], alu_res == '0, alu_c, alu_v};
        end
    end

    assign n = flags[arm_pkg::FLAG_N];
    assign z = flags[arm_pkg::FLAG_Z];
    assign c = flags[arm_pkg::FLAG_C];
    assign v = flags[arm_pkg::FLAG_V];

    always_comb begin
        case (ex_cond)
            4'h0:    cond_ok = z;               // EQ
            4'h1:    cond_ok = ~z;
            4'h2:    cond_ok = c;
            4'h3:    cond_ok = ~c;
            4'h4:    cond_ok = n;
            4'h5:    cond_ok = ~n;
            4'h6:    cond_ok = v;
            4'h7:    cond_ok = ~v;
            4'h8:    cond_ok = c & ~z;          // HI
            4'h9:    cond_ok = ~c | z;
            4'ha:    cond_ok = (n == v);        // GE
            4'hb:    cond_ok = (n != v);
            4'hc:    cond_ok = ~z & (n == v);
            4'hd:    cond_ok = z | (n != v);    // LE
            4'he:    cond_ok = 1'b1;
            default: cond_ok = 1'b0;            // NV
        endcase
    end

    // Word offset, sign-extended from bit 23
    assign br_offset     = {{6{ex_b_raw[23]}}, ex_b_raw[23:0], 2'b00};
    assign branch_taken  = ex_is_branch && cond_ok;
    assign branch_target = ex_pc + 32'd4 + br_offset;

    assign ex_fwd_valid = ex_write;
    assign ex_fwd_reg   = ex_rd;
    assign ex_fwd_data  = alu_res;

    // Execute/writeback register
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= ex_write;
        end
    end

    always_ff @(posedge clk) begin
        wb_reg  <= ex_rd;
        wb_data <= alu_res;
    end

endmodule

// ==== design/arm_core.sv ====
`timescale 1ns/10ps

module arm_core #(
    parameter int IMEM_WORDS = 64
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               run,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  arm_pkg::word_t     paddr,
    input  arm_pkg::word_t     pwdata,
    output arm_pkg::word_t     prdata,
    output logic               pready,
    output logic               wb_valid,
    output arm_pkg::reg_idx_t  wb_reg,
    output arm_pkg::word_t     wb_data,
    output arm_pkg::flags_t    flags
);

    arm_pkg::word_t    if_instr;
    arm_pkg::word_t    if_pc;
    arm_pkg::alu_op_t  ex_op;
    logic              ex_set_flags;
    logic              ex_write;
    logic              ex_is_branch;
    arm_pkg::cond_t    ex_cond;
    arm_pkg::word_t    ex_a;
    arm_pkg::word_t    ex_b_raw;
    logic [11:0]       ex_imm12;
    logic              ex_use_imm;
    arm_pkg::reg_idx_t ex_rd;
    arm_pkg::word_t    ex_pc;
    logic              ex_fwd_valid;
    arm_pkg::reg_idx_t ex_fwd_reg;
    arm_pkg::word_t    ex_fwd_data;
    logic              branch_taken;
    arm_pkg::word_t    branch_target;

    fetch_stage #(
        .IMEM_WORDS(IMEM_WORDS)
    ) fetch_i (
        .clk(clk), .rst(rst), .run(run),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata),
        .branch_taken(branch_taken), .branch_target(branch_target),
        .prdata(prdata), .pready(pready),
        .if_instr(if_instr), .if_pc(if_pc)
    );

    decode_stage decode_i (
        .clk(clk), .rst(rst), .branch_taken(branch_taken),
        .if_instr(if_instr), .if_pc(if_pc),
        .wb_valid(wb_valid), .wb_reg(wb_reg), .wb_data(wb_data),
        .ex_fwd_valid(ex_fwd_valid), .ex_fwd_reg(ex_fwd_reg), .ex_fwd_data(ex_fwd_data),
        .ex_op(ex_op), .ex_set_flags(ex_set_flags), .ex_write(ex_write),
        .ex_is_branch(ex_is_branch), .ex_cond(ex_cond),
        .ex_a(ex_a), .ex_b_raw(ex_b_raw), .ex_imm12(ex_imm12), .ex_use_imm(ex_use_imm),
        .ex_rd(ex_rd), .ex_pc(ex_pc)
    );

    execute_stage execute_i (
        .clk(clk), .rst(rst),
        .ex_op(ex_op), .ex_set_flags(ex_set_flags), .ex_write(ex_write),
        .ex_is_branch(ex_is_branch), .ex_cond(ex_cond),
        .ex_a(ex_a), .ex_b_raw(ex_b_raw), .ex_imm12(ex_imm12), .ex_use_imm(ex_use_imm),
        .ex_rd(ex_rd), .ex_pc(ex_pc),
        .ex_fwd_valid(ex_fwd_valid), .ex_fwd_reg(ex_fwd_reg), .ex_fwd_data(ex_fwd_data),
        .wb_valid(wb_valid), .wb_reg(wb_reg), .wb_data(wb_data),
        .flags(flags),
        .branch_taken(branch_taken), .branch_target(branch_target)
    );

endmodule

// ==== tests/tb_model.svh ====
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

logic [31:0] lfsr_state = 32'h8b15_d252;
int          fill_idx;

localparam logic [3:0] KEPT_OPS [11] = '{4'h0, 4'h1, 4'h2, 4'h3, 4'h4, 4'ha, 4'hb,
                                         4'hc, 4'hd, 4'he, 4'hf};

// One LFSR step per bit taken
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
        r = {r[30:0], lfsr_state[0]};
        lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
    end
    return r;
endfunction

function automatic arm_pkg::word_t dp_r(input logic [3:0] cond, input logic [3:0] opc,
        input logic s, input logic [3:0] rd, input logic [3:0] rn, input logic [3:0] rm,
        input logic [1:0] sh, input logic [4:0] amt);
    return {cond, 3'b000, opc, s, rn, rd, amt, sh, 1'b0, rm};
endfunction

function automatic arm_pkg::word_t dp_i(input logic [3:0] cond, input logic [3:0] opc,
        input logic s, input logic [3:0] rd, input logic [3:0] rn, input logic [3:0] rot,
        input logic [7:0] imm);
    return {cond, 3'b001, opc, s, rn, rd, rot, imm};
endfunction

function automatic arm_pkg::word_t br(input logic [3:0] cond, input logic [23:0] off);
    return {cond, 3'b101, 1'b0, off};
endfunction

function automatic void emit(input arm_pkg::word_t w);
    prog[fill_idx] = w;
    fill_idx++;
endfunction

// NOP fill followed by random immediates into R0 to R13
function automatic void gen_init();
    for (int i = 0; i < IMEM_WORDS; i++) begin
        prog[i] = arm_pkg::NOP_WORD;
    end
    fill_idx = 0;
    for (int r = 0; r < 14; r++) begin
        emit(dp_i(4'he, arm_pkg::OPC_MOV, 1'b0, 4'(r), 4'h0, 4'(rand_bits(4)), 8'(rand_bits(8))));
    end
endfunction

function automatic void gen_random();
    logic [2:0] kind;
    logic [3:0] opc;
    gen_init();
    while (fill_idx < PROG_LEN) begin
        kind = 3'(rand_bits(3));
        opc  = KEPT_OPS[rand_bits(4) % 11];
        if (kind == 3'd7) begin
            emit(br(4'(rand_bits(4)), 24'(rand_bits(2))));   // Forward only
        end else if (kind[0]) begin
            emit(dp_i(4'(rand_bits(4)), opc, rand_bits(1) != 0, 4'(rand_bits(4) % 14),
                      4'(rand_bits(4) % 14), 4'(rand_bits(4)), 8'(rand_bits(8))));
        end else begin
            emit(dp_r(4'(rand_bits(4)), opc, rand_bits(1) != 0, 4'(rand_bits(4) % 14),
                      4'(rand_bits(4) % 14), 4'(rand_bits(4) % 14), 2'(rand_bits(2)),
                      5'(rand_bits(5))));
        end
    end
endfunction

function automatic arm_pkg::word_t rotr(input arm_pkg::word_t x, input int sh);
    if (sh == 0) begin
        return x;
    end
    return (x >> sh) | (x << (32 - sh));
endfunction

function automatic logic cond_holds(input logic [3:0] cond, input arm_pkg::flags_t f);
    logic n;
    logic z;
    logic c;
    logic v;
    {n, z, c, v} = f;
    case (cond)
        4'h0: return z;
        4'h1: return !z;
        4'h2: return c;
        4'h3: return !c;
        4'h4: return n;
        4'h5: return !n;
        4'h6: return v;
        4'h7: return !v;
        4'h8: return c && !z;
        4'h9: return !c || z;
        4'ha: return n == v;
        4'hb: return n != v;
        4'hc: return !z && (n == v);
        4'hd: return z || (n != v);
        4'he: return 1'b1;
        default: return 1'b0;
    endcase
endfunction

// Instruction-level reference for the expected writes and flags
function automatic void run_model();
    arm_pkg::word_t  regs [16];
    arm_pkg::word_t  pc;
    arm_pkg::word_t  ins;
    arm_pkg::word_t  a;
    arm_pkg::word_t  b;
    arm_pkg::word_t  res;
    arm_pkg::flags_t f;
    logic [3:0]      opc;
    logic            c;
    logic            v;
    logic            wr;
    logic            setf;
    int              steps;
    for (int i = 0; i < 16; i++) begin
        regs[i] = '0;
    end
    exp_reg.delete();
    exp_data.delete();
    exp_wflags.delete();
    f = '0;
    pc = '0;
    steps = 0;
    while ((pc >> 2) < IMEM_WORDS && steps < 4 * IMEM_WORDS) begin
        ins = prog[pc >> 2];
        pc = pc + 4;
        steps++;
        if (ins[27:25] == arm_pkg::CLASS_BRANCH && !ins[24]) begin
            if (cond_holds(ins[31:28], f)) begin
                pc = pc + {{6{ins[23]}}, ins[23:0], 2'b00};
            end
        end else if (ins != 0 && (ins[27:25] == arm_pkg::CLASS_DP_IMM ||
                                  (ins[27:25] == arm_pkg::CLASS_DP_REG && !ins[4]))) begin
            a = regs[ins[19:16]];
            if (ins[25]) begin
                b = rotr({24'h0, ins[7:0]}, 2 * ins[11:8]);
            end else begin
                b = regs[ins[3:0]];
                case (ins[6:5])
                    2'd0: b = b << ins[11:7];
                    2'd1: b = b >> ins[11:7];
                    2'd2: b = $signed(b) >>> ins[11:7];
                    default: b = rotr(b, ins[11:7]);
                endcase
            end
            opc = ins[24:21];
            c = 1'b0;
            v = 1'b0;
            wr = 1'b1;
            setf = ins[20];
            res = '0;
            case (opc)
                arm_pkg::OPC_AND: res = a & b;
                arm_pkg::OPC_EOR: res = a ^ b;
                arm_pkg::OPC_ORR: res = a | b;
                arm_pkg::OPC_MOV: res = b;
                arm_pkg::OPC_BIC: res = a & ~b;
                arm_pkg::OPC_MVN: res = ~b;
                arm_pkg::OPC_SUB, arm_pkg::OPC_CMP: begin
                    res = a - b;
                    c = a < b;   // Borrow
                    v = (a[31] != b[31]) && (res[31] != a[31]);
                end
                arm_pkg::OPC_RSB: begin
                    res = b - a;
                    c = b < a;
                    v = (a[31] != b[31]) && (res[31] != b[31]);
                end
                arm_pkg::OPC_ADD, arm_pkg::OPC_CMN: begin
                    {c, res} = {1'b0, a} + {1'b0, b};
                    v = (a[31] == b[31]) && (res[31] != a[31]);
                end
                default: begin
                    wr = 1'b0;
                    setf = 1'b0;
                end
            endcase
            if (opc == arm_pkg::OPC_CMP || opc == arm_pkg::OPC_CMN) begin
                wr = 1'b0;
                setf = 1'b1;
            end
            if (setf) begin
                f = {res[31], res == 0, c, v};
            end
            if (wr) begin
                regs[ins[15:12]] = res;
                exp_reg.push_back(ins[15:12]);
                exp_data.push_back(res);
                exp_wflags.push_back(f);   // Flags as seen alongside this write
            end
        end
    end
    exp_flags = f;
endfunction

`endif

// ==== tests/tb_top.sv ====
`timescale 1ns/10ps

module tb_top;

    localparam int IMEM_WORDS  = 64;
    localparam int PROG_LEN    = 40;
    localparam int NUM_RANDOM  = 6;
    localparam int NUM_RUNS    = NUM_RANDOM + 3;
    localparam int RUN_CYCLES  = 4 * IMEM_WORDS + 50;
    localparam int CYCLE_LIMIT = NUM_RUNS * (RUN_CYCLES + 6 * IMEM_WORDS + 30) + 100;

    logic              clk;
    logic              rst;
    logic              run;
    logic              psel;
    logic              penable;
    logic              pwrite;
    arm_pkg::word_t    paddr;
    arm_pkg::word_t    pwdata;
    arm_pkg::word_t    prdata;
    logic              pready;
    logic              wb_valid;
    arm_pkg::reg_idx_t wb_reg;
    arm_pkg::word_t    wb_data;
    arm_pkg::flags_t   flags;

    arm_pkg::word_t    prog [IMEM_WORDS];
    arm_pkg::reg_idx_t exp_reg [$];
    arm_pkg::word_t    exp_data [$];
    arm_pkg::flags_t   exp_wflags [$];
    arm_pkg::flags_t   exp_flags;
    int                mismatches = 0;
    int                failures = 0;
    int                writes_seen = 0;
    int                cycles = 0;

    `include "tb_model.svh"

    arm_core #(.IMEM_WORDS(IMEM_WORDS)) dut_i (
        .clk(clk), .rst(rst), .run(run),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .wb_valid(wb_valid), .wb_reg(wb_reg), .wb_data(wb_data), .flags(flags)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            mismatches++;
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // Writeback monitor
    always @(negedge clk) begin
        if (!rst && wb_valid === 1'b1) begin
            writes_seen++;
            if (exp_reg.size() == 0) begin
                failures++;
                $display("Unexpected write to R%0d at %0t", wb_reg, $time);
            end else begin
                check_value("wb_reg", 32'(wb_reg), 32'(exp_reg.pop_front()));
                check_value("wb_data", wb_data, exp_data.pop_front());
                check_value("flags", 32'(flags), 32'(exp_wflags.pop_front()));
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles", cycles);
            $display("Verification failed");
            $finish;
        end
    end

    task automatic apb_xfer(input logic wr, input arm_pkg::word_t addr,
                            input arm_pkg::word_t wdata, output arm_pkg::word_t rdata);
        @(posedge clk);
        psel    <= 1'b1;         // Setup phase
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        if (pready !== 1'b1) begin
            failures++;
            $display("APB slave not ready in access phase at %0t", $time);
        end
        rdata = prdata;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic load_and_run();
        arm_pkg::word_t rd;
        int             n;
        @(posedge clk);
        rst <= 1'b1;
        run <= 1'b0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        repeat (3) @(negedge clk);
        check_value("flags", 32'(flags), 32'h0);   // Idle after reset
        check_value("wb_valid", 32'(wb_valid), 32'h0);
        for (int i = 0; i < IMEM_WORDS; i++) begin
            apb_xfer(1'b1, 32'(i * 4), prog[i], rd);
        end
        for (int i = 0; i < IMEM_WORDS; i++) begin
            apb_xfer(1'b0, 32'(i * 4), '0, rd);
            check_value("prdata", rd, prog[i]);
        end
        run_model();
        n = exp_reg.size();
        writes_seen = 0;
        @(posedge clk);
        run <= 1'b1;
        // Longest run, taken branches refetch their two followers
        repeat (RUN_CYCLES) @(posedge clk);
        @(negedge clk);
        check_value("write_count", 32'(writes_seen), 32'(n));
        check_value("flags", 32'(flags), 32'(exp_flags));
        @(posedge clk);
        run <= 1'b0;
    endtask

    initial begin
        rst     = 1'b1;
        run     = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;

        // Dependent chain through both forwarding paths
        gen_init();
        emit(dp_r(4'he, arm_pkg::OPC_ADD, 1'b0, 4'd1, 4'd2, 4'd3, 2'd0, 5'd3));
        emit(dp_i(4'he, arm_pkg::OPC_SUB, 1'b0, 4'd4, 4'd1, 4'd2, 8'h3f));
        emit(dp_r(4'he, arm_pkg::OPC_EOR, 1'b0, 4'd5, 4'd1, 4'd4, 2'd1, 5'd7));
        emit(dp_r(4'he, arm_pkg::OPC_ORR, 1'b0, 4'd6, 4'd5, 4'd4, 2'd2, 5'd31));
        emit(dp_r(4'he, arm_pkg::OPC_RSB, 1'b0, 4'd7, 4'd6, 4'd5, 2'd3, 5'd13));
        emit(dp_i(4'he, arm_pkg::OPC_BIC, 1'b0, 4'd8, 4'd7, 4'd1, 8'hff));
        emit(dp_r(4'he, arm_pkg::OPC_MVN, 1'b0, 4'd9, 4'd0, 4'd8, 2'd3, 5'd0));
        emit(dp_i(4'he, arm_pkg::OPC_MOV, 1'b0, 4'd10, 4'd0, 4'd15, 8'hab));
        emit(dp_r(4'he, arm_pkg::OPC_AND, 1'b0, 4'd11, 4'd10, 4'd9, 2'd0, 5'd31));
        emit(dp_r(4'he, arm_pkg::OPC_ADD, 1'b0, 4'd11, 4'd11, 4'd11, 2'd0, 5'd0));
        load_and_run();

        // Carry and overflow cases, each compare followed by a write that shows its flags
        gen_init();
        emit(dp_i(4'he, arm_pkg::OPC_MOV, 1'b0, 4'd0, 4'd0, 4'd0, 8'h01));
        emit(dp_i(4'he, arm_pkg::OPC_MOV, 1'b0, 4'd1, 4'd0, 4'd4, 8'h80));
        emit(dp_r(4'he, arm_pkg::OPC_CMP, 1'b1, 4'd0, 4'd1, 4'd0, 2'd0, 5'd0));
        emit(dp_i(4'he, arm_pkg::OPC_MOV, 1'b0, 4'd6, 4'd0, 4'd0, 8'h06));
        emit(dp_r(4'he, arm_pkg::OPC_ADD, 1'b1, 4'd2, 4'd1, 4'd1, 2'd0, 5'd0));
        emit(dp_i(4'he, arm_pkg::OPC_MVN, 1'b1, 4'd3, 4'd0, 4'd0, 8'h00));
        emit(dp_r(4'he, arm_pkg::OPC_SUB, 1'b1, 4'd4, 4'd0, 4'd3, 2'd0, 5'd0));
        emit(dp_r(4'he, arm_pkg::OPC_CMN, 1'b1, 4'd0, 4'd1, 4'd1, 2'd0, 5'd0));
        emit(dp_i(4'he, arm_pkg::OPC_MOV, 1'b0, 4'd7, 4'd0, 4'd0, 8'h07));
        emit(dp_r(4'he, arm_pkg::OPC_CMP, 1'b1, 4'd0, 4'd0, 4'd0, 2'd0, 5'd0));
        emit(dp_i(4'he, arm_pkg::OPC_MOV, 1'b0, 4'd8, 4'd0, 4'd0, 8'h08));
        emit(dp_i(4'he, arm_pkg::OPC_RSB, 1'b1, 4'd5, 4'd0, 4'd0, 8'h00));
        load_and_run();

        // Taken and not-taken branches
        gen_init();
        emit(dp_i(4'he, arm_pkg::OPC_MOV, 1'b0, 4'd0, 4'd0, 4'd0, 8'h05));
        emit(dp_i(4'he, arm_pkg::OPC_CMP, 1'b1, 4'd0, 4'd0, 4'd0, 8'h05));
        emit(br(4'h0, 24'd2));
        emit(dp_i(4'he, arm_pkg::OPC_MOV, 1'b0, 4'd1, 4'd0, 4'd0, 8'h01));
        emit(dp_i(4'he, arm_pkg::OPC_MOV, 1'b0, 4'd2, 4'd0, 4'd0, 8'h02));
        emit(br(4'h1, 24'd1));
        emit(dp_i(4'he, arm_pkg::OPC_MOV, 1'b0, 4'd3, 4'd0, 4'd0, 8'h03));
        emit(dp_i(4'he, arm_pkg::OPC_MOV, 1'b0, 4'd4, 4'd0, 4'd0, 8'h04));
        emit(dp_i(4'he, arm_pkg::OPC_CMP, 1'b1, 4'd0, 4'd0, 4'd0, 8'h06));
        emit(br(4'hb, 24'd0));
        emit(dp_i(4'he, arm_pkg::OPC_MOV, 1'b0, 4'd5, 4'd0, 4'd0, 8'h05));
        emit(br(4'h4, 24'd1));
        emit(dp_i(4'he, arm_pkg::OPC_MOV, 1'b0, 4'd6, 4'd0, 4'd0, 8'h06));
        emit(dp_i(4'he, arm_pkg::OPC_MOV, 1'b0, 4'd7, 4'd0, 4'd0, 8'h07));
        emit(br(4'he, 24'd3));
        emit(dp_i(4'he, arm_pkg::OPC_MOV, 1'b0, 4'd8, 4'd0, 4'd0, 8'h08));
        emit(dp_i(4'he, arm_pkg::OPC_MOV, 1'b0, 4'd9, 4'd0, 4'd0, 8'h09));
        emit({4'he, 3'b101, 1'b1, 24'd0});    // BL decodes as NOP
        emit(br(4'hf, 24'd1));
        emit(dp_i(4'he, arm_pkg::OPC_MOV, 1'b0, 4'd10, 4'd0, 4'd0, 8'h0a));
        load_and_run();

        for (int p = 0; p < NUM_RANDOM; p++) begin
            gen_random();
            load_and_run();
        end

        $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+tests
design/arm_pkg.sv
design/fetch_stage.sv
design/decode_stage.sv
design/execute_stage.sv
design/arm_core.sv
tests/tb_top.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module tb_top -f flist.f -o sim_tb
	out="$$(./obj_dir/sim_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Verification passed$$"

clean:
	rm -rf obj_dir
